// ==== all.f ====
+incdir+rtl
rtl/qupls_pkg.sv
rtl/qupls_agen.sv
rtl/qupls_mem_decode.sv
rtl/qupls_mem_align.sv
rtl/qupls_lsu_front.sv
bench/qupls_lsu_front_checker.sv
bench/qupls_lsu_front_sva.sv
bench/qupls_lsu_front_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
TOP        := qupls_lsu_front_tb
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Something failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run counts as failed when the log holds the fail message or the binary aborts
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/qupls_lsu_front_tb.sv ====
`timescale 1ns/1ps
`include "qupls_config.svh"

module qupls_lsu_front_tb
	import qupls_pkg::*;
();

	localparam int CLK_HALF     = 2;
	localparam int CLK_PERIOD   = 2 * CLK_HALF;
	localparam int RESET_CYCLES = 3;
	localparam int MAX_GAP      = 2;

	// Fixed operands are multiples of eight, so the row offset alone sets the low address bits
	localparam value_t FIX_BASE  = 64'h0000_7f00_0000_1000;
	localparam value_t FIX_INDEX = 64'h0000_0000_0000_0128;
	localparam value_t FIX_IMM   = 64'hffff_ffff_ffff_fff0;

	// Each table row holds the stimulus fields first and the expected attributes after them
	typedef struct packed {
		opcode_e    opc;
		logic [1:0] sc;
		acc_size_e  sz;
		logic       rnd;
		logic [7:0] off;
		logic       mem;
		acc_size_e  e_size;
		logic       e_sign;
		logic       e_store;
		logic [1:0] gap;
	} entry_t;

	logic                    clk = 1'b0;
	logic                    rst;
	logic                    issue;
	instruction_t            ir;
	value_t                  a;
	value_t                  b;
	value_t                  i;
	logic                    exp_valid;
	acc_size_e               exp_size;
	logic                    exp_sign;
	logic                    exp_store;
	logic                    req_valid;
	value_t                  addr;
	acc_size_e               size;
	logic                    sign_ext;
	logic                    is_store;
	logic [`QUPLS_LANES-1:0] sel;
	logic                    misalign;
	int                      value_errors;
	int                      strobe_errors;
	entry_t                  tbl[$];
	logic [15:0]             lfsr_state;
	logic                    table_ready = 1'b0;

	always #CLK_HALF clk = ~clk;

	qupls_lsu_front i_dut (
		.clk(clk), .rst(rst), .issue(issue), .ir(ir), .a(a), .b(b), .i(i),
		.req_valid(req_valid), .addr(addr), .size(size), .sign_ext(sign_ext),
		.is_store(is_store), .sel(sel), .misalign(misalign)
	);

	// Predicts each output from the row that was issued one cycle earlier
	qupls_lsu_front_checker i_check (
		.clk(clk), .rst(rst), .issue(issue), .ir(ir), .a(a), .b(b), .i(i),
		.exp_valid(exp_valid), .exp_size(exp_size), .exp_sign(exp_sign),
		.exp_store(exp_store), .req_valid(req_valid), .addr(addr), .size(size),
		.sign_ext(sign_ext), .is_store(is_store), .sel(sel), .misalign(misalign),
		.value_errors(value_errors), .strobe_errors(strobe_errors)
	);

	// ======================================================================
	// Operand source
	// ======================================================================

	// Fibonacci LFSR with taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step for every bit that goes into the value
	task automatic draw_bits(input int n, output value_t v);
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v[k] = lfsr_state[0];
		end
	endtask

	// ======================================================================
	// Table and driver
	// ======================================================================

	task automatic add_entry(input opcode_e opc, input logic [1:0] sc, input acc_size_e sz,
		input logic rnd, input logic [7:0] off, input logic mem, input acc_size_e e_size,
		input logic e_sign, input logic e_store, input logic [1:0] gap);
		tbl.push_back('{opc, sc, sz, rnd, off, mem, e_size, e_sign, e_store, gap});
	endtask

	task automatic fill_table();
		// Aligned plain loads and stores with several of them back to back
		add_entry(OP_LDB,  2'd0, SZ_BYTE,  1'b0, 8'h03, 1'b1, SZ_BYTE,  1'b1, 1'b0, 2'd1);
		add_entry(OP_LDBU, 2'd0, SZ_BYTE,  1'b0, 8'h07, 1'b1, SZ_BYTE,  1'b0, 1'b0, 2'd0);
		add_entry(OP_LDW,  2'd0, SZ_WYDE,  1'b0, 8'h06, 1'b1, SZ_WYDE,  1'b1, 1'b0, 2'd0);
		add_entry(OP_LDWU, 2'd0, SZ_WYDE,  1'b0, 8'h02, 1'b1, SZ_WYDE,  1'b0, 1'b0, 2'd1);
		// Neither the scale nor the size field may matter for a plain form
		add_entry(OP_LDT,  2'd2, SZ_BYTE,  1'b0, 8'h04, 1'b1, SZ_TETRA, 1'b1, 1'b0, 2'd0);
		add_entry(OP_LDTU, 2'd0, SZ_TETRA, 1'b0, 8'h00, 1'b1, SZ_TETRA, 1'b0, 1'b0, 2'd0);
		add_entry(OP_LDO,  2'd0, SZ_OCTA,  1'b0, 8'h00, 1'b1, SZ_OCTA,  1'b1, 1'b0, 2'd2);
		add_entry(OP_STB,  2'd0, SZ_BYTE,  1'b0, 8'h05, 1'b1, SZ_BYTE,  1'b0, 1'b1, 2'd0);
		// A plain store takes its width from the opcode alone
		add_entry(OP_STW,  2'd0, SZ_OCTA,  1'b0, 8'h04, 1'b1, SZ_WYDE,  1'b0, 1'b1, 2'd0);
		add_entry(OP_STT,  2'd0, SZ_TETRA, 1'b0, 8'h00, 1'b1, SZ_TETRA, 1'b0, 1'b1, 2'd1);
		add_entry(OP_STO,  2'd0, SZ_OCTA,  1'b0, 8'h00, 1'b1, SZ_OCTA,  1'b0, 1'b1, 2'd0);
		// Indexed forms take their size from the instruction field
		add_entry(OP_LDX,  2'd0, SZ_BYTE,  1'b0, 8'h01, 1'b1, SZ_BYTE,  1'b1, 1'b0, 2'd0);
		add_entry(OP_LDX,  2'd1, SZ_WYDE,  1'b0, 8'h02, 1'b1, SZ_WYDE,  1'b1, 1'b0, 2'd0);
		add_entry(OP_STX,  2'd2, SZ_TETRA, 1'b0, 8'h04, 1'b1, SZ_TETRA, 1'b0, 1'b1, 2'd0);
		add_entry(OP_STX,  2'd3, SZ_OCTA,  1'b0, 8'h00, 1'b1, SZ_OCTA,  1'b0, 1'b1, 2'd1);
		add_entry(OP_STX,  2'd1, SZ_BYTE,  1'b0, 8'h00, 1'b1, SZ_BYTE,  1'b0, 1'b1, 2'd0);
		// The atomic ignores both the scale and the size field
		add_entry(OP_AMO,  2'd3, SZ_BYTE,  1'b0, 8'h00, 1'b1, SZ_OCTA,  1'b0, 1'b0, 2'd0);
		add_entry(OP_ADD,  2'd0, SZ_BYTE,  1'b0, 8'h00, 1'b0, SZ_BYTE,  1'b0, 1'b0, 2'd0);
		// Misaligned wyde, tetra and octa
		add_entry(OP_LDW,  2'd0, SZ_WYDE,  1'b0, 8'h01, 1'b1, SZ_WYDE,  1'b1, 1'b0, 2'd0);
		add_entry(OP_STT,  2'd0, SZ_TETRA, 1'b0, 8'h06, 1'b1, SZ_TETRA, 1'b0, 1'b1, 2'd0);
		add_entry(OP_LDX,  2'd1, SZ_OCTA,  1'b0, 8'h03, 1'b1, SZ_OCTA,  1'b1, 1'b0, 2'd1);
		// LFSR operands
		add_entry(OP_AMO,  2'd1, SZ_BYTE,  1'b1, 8'h00, 1'b1, SZ_OCTA,  1'b0, 1'b0, 2'd0);
		add_entry(OP_LDX,  2'd2, SZ_TETRA, 1'b1, 8'h00, 1'b1, SZ_TETRA, 1'b1, 1'b0, 2'd0);
		add_entry(OP_LDX,  2'd3, SZ_OCTA,  1'b1, 8'h00, 1'b1, SZ_OCTA,  1'b1, 1'b0, 2'd0);
		add_entry(OP_STX,  2'd0, SZ_WYDE,  1'b1, 8'h00, 1'b1, SZ_WYDE,  1'b0, 1'b1, 2'd0);
		add_entry(OP_ADD,  2'd0, SZ_BYTE,  1'b1, 8'h00, 1'b0, SZ_BYTE,  1'b0, 1'b0, 2'd0);
	endtask

	task automatic drive_idle();
		issue     = 1'b0;
		exp_valid = 1'b0;
		exp_size  = SZ_BYTE;
		exp_sign  = 1'b0;
		exp_store = 1'b0;
	endtask

	task automatic apply_entry(input entry_t e);
		value_t imm16;
		ir            = '0;
		ir.lsn.opcode = e.opc;
		ir.lsn.sc     = e.sc;
		ir.lsn.sz     = e.sz;
		ir.lsn.rt     = 6'd3;
		ir.lsn.ra     = 6'd5;
		ir.lsn.rb     = 6'd9;
		if (e.rnd)
		begin
			draw_bits(64, a);
			draw_bits(64, b);
			// The immediate arrives sign-extended from 16 bits
			draw_bits(16, imm16);
			i = {{48{imm16[15]}}, imm16[15:0]};
		end
		else
		begin
			a = FIX_BASE + 64'(e.off);
			b = FIX_INDEX;
			i = FIX_IMM;
		end
		issue     = 1'b1;
		exp_valid = e.mem;
		exp_size  = e.e_size;
		exp_sign  = e.e_sign;
		exp_store = e.e_store;
	endtask

	// ======================================================================
	// Run control
	// ======================================================================

	initial
	begin
		rst = 1'b1;
		ir  = '0;
		a   = '0;
		b   = '0;
		i   = '0;
		drive_idle();
		lfsr_state = 16'd86;
		fill_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		foreach (tbl[k])
		begin
			@(negedge clk);
			apply_entry(tbl[k]);
			repeat (tbl[k].gap)
			begin
				@(negedge clk);
				drive_idle();
			end
		end
		@(negedge clk);
		drive_idle();
		// Reset on the same edge as an issue has to swallow the request
		@(negedge clk);
		apply_entry(tbl[0]);
		rst = 1'b1;
		@(negedge clk);
		rst = 1'b0;
		drive_idle();
		repeat (3) @(negedge clk);
		// The checker compares on the falling edge, so its counts settle by the next rising edge
		@(posedge clk);
		$display("Error counts: %0d wrong values, %0d strobe mismatches",
			value_errors, strobe_errors);
		if (value_errors == 0 && strobe_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Worst case every row waits MAX_GAP idle cycles
	initial
	begin
		int limit_cycles;
		wait (table_ready);
		limit_cycles = tbl.size() * (1 + MAX_GAP) + RESET_CYCLES + 20;
		#(limit_cycles * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the stimulus loop never finished",
			limit_cycles);
		$display("Error counts: %0d wrong values, %0d strobe mismatches",
			value_errors, strobe_errors);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== bench/qupls_lsu_front_sva.sv ====
`timescale 1ns/1ps
`include "qupls_config.svh"

module qupls_lsu_front_sva
	import qupls_pkg::*;
(
	input logic                    clk,
	input logic                    rst,
	input logic                    issue,
	input instruction_t            ir,
	input logic                    req_valid,
	input logic [`QUPLS_LANES-1:0] sel,
	input logic                    misalign
);

	function automatic logic is_mem_op(input instruction_t insn);
		return insn.any.opcode inside {OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU,
			OP_LDO, OP_STB, OP_STW, OP_STT, OP_STO, OP_LDX, OP_STX, OP_AMO};
	endfunction

	// A reset cycle leaves nothing behind on the next edge
	reset_clears: assert property (@(posedge clk) rst |=> (!req_valid && !misalign && sel == '0))
		else $error("Outputs not cleared one cycle after reset");

	idle_quiet: assert property (@(posedge clk) disable iff (rst)
		!req_valid |-> (sel == '0 && !misalign))
		else $error("Lane select or misalign active without a request");

	misalign_no_lanes: assert property (@(posedge clk) disable iff (rst) misalign |-> sel == '0)
		else $error("Misaligned request still selects lanes");

	// Exactly one strobe per memory issue, one cycle later
	strobe_follows: assert property (@(posedge clk) disable iff (rst)
		(issue && is_mem_op(ir)) |=> req_valid)
		else $error("Memory issue not followed by req_valid");

	strobe_only_after_issue: assert property (@(posedge clk) disable iff (rst)
		!(issue && is_mem_op(ir)) |=> !req_valid)
		else $error("req_valid without a preceding memory issue");

endmodule

bind qupls_lsu_front qupls_lsu_front_sva i_sva (
	.clk(clk), .rst(rst), .issue(issue), .ir(ir),
	.req_valid(req_valid), .sel(sel), .misalign(misalign)
);

// ==== bench/qupls_lsu_front_checker.sv ====
`timescale 1ns/1ps
`include "qupls_config.svh"

module qupls_lsu_front_checker
	import qupls_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    issue,
	input  instruction_t            ir,
	input  value_t                  a,
	input  value_t                  b,
	input  value_t                  i,
	input  logic                    exp_valid,
	input  acc_size_e               exp_size,
	input  logic                    exp_sign,
	input  logic                    exp_store,
	input  logic                    req_valid,
	input  value_t                  addr,
	input  acc_size_e               size,
	input  logic                    sign_ext,
	input  logic                    is_store,
	input  logic [`QUPLS_LANES-1:0] sel,
	input  logic                    misalign,
	output int                      value_errors,
	output int                      strobe_errors
);

	int n_value = 0;
	int n_strobe = 0;

	assign value_errors  = n_value;
	assign strobe_errors = n_strobe;

	// ======================================================================
	// Inputs of the previous cycle
	// ======================================================================

	logic         primed = 1'b0;
	logic         p_rst;
	logic         p_issue;
	instruction_t p_ir;
	value_t       p_a;
	value_t       p_b;
	value_t       p_i;
	logic         p_valid;
	acc_size_e    p_size;
	logic         p_sign;
	logic         p_store;

	always @(posedge clk)
	begin
		primed  <= 1'b1;
		p_rst   <= rst;
		p_issue <= issue;
		p_ir    <= ir;
		p_a     <= a;
		p_b     <= b;
		p_i     <= i;
		p_valid <= exp_valid;
		p_size  <= exp_size;
		p_sign  <= exp_sign;
		p_store <= exp_store;
	end

	// ======================================================================
	// Reference rules
	// ======================================================================

	// Indexed forms multiply the index by 1, 2, 4 or 8, the atomic adds it plainly
	function automatic value_t predict_addr(input opcode_e op, input logic [1:0] sc,
		input value_t base, input value_t idx, input value_t imm);
		value_t scale;
		case (sc)
			2'd0: scale = 64'd1;
			2'd1: scale = 64'd2;
			2'd2: scale = 64'd4;
			default: scale = 64'd8;
		endcase
		if (op == OP_LDX || op == OP_STX)
			return base + idx * scale + imm;
		else if (op == OP_AMO)
			return base + idx;
		return base + imm;
	endfunction

	task automatic check_value(input string name, input value_t want, input value_t got);
		if (got !== want)
		begin
			n_value++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, want, got);
		end
	endtask

	// Outputs are stable at the falling edge, half a cycle after they were registered
	always @(negedge clk)
	begin
		logic                    w_valid;
		value_t                  w_addr;
		acc_size_e               w_size;
		logic [`QUPLS_LANES-1:0] w_sel;
		logic                    w_mis;
		int                      nbytes;
		int                      lane;
		if (primed)
		begin
			w_valid = !p_rst && p_issue && p_valid;
			w_addr  = w_valid ? predict_addr(p_ir.any.opcode, p_ir.lsn.sc, p_a, p_b, p_i) : '0;
			w_size  = w_valid ? p_size : SZ_BYTE;
			nbytes  = 1 << int'(w_size);
			lane    = int'(w_addr % `QUPLS_LANES);
			// Aligned means the start lane is a whole multiple of the access width
			w_mis   = w_valid && (lane % nbytes != 0);
			for (int k = 0; k < `QUPLS_LANES; k++)
				w_sel[k] = w_valid && !w_mis && k >= lane && k < lane + nbytes;
			if (req_valid !== w_valid)
			begin
				n_strobe++;
				if (w_valid)
					$display("At %0t req_valid stayed low after an issue of %s", $time,
						p_ir.any.opcode.name());
				else
					$display("At %0t req_valid was high with no memory issue before it", $time);
			end
			check_value("addr", w_addr, addr);
			check_value("size", 64'(w_size), 64'(size));
			check_value("sign_ext", 64'(!p_rst && p_issue && p_sign), 64'(sign_ext));
			check_value("is_store", 64'(!p_rst && p_issue && p_store), 64'(is_store));
			check_value("sel", 64'(w_sel), 64'(sel));
			check_value("misalign", 64'(w_mis), 64'(misalign));
		end
	end

endmodule

// ==== rtl/qupls_lsu_front.sv ====
`timescale 1ns/1ps
`include "qupls_config.svh"

module qupls_lsu_front
	import qupls_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     issue,
	input  instruction_t             ir,
	input  value_t                   a,
	input  value_t                   b,
	input  value_t                   i,
	output logic                     req_valid,
	output value_t                   addr,
	output acc_size_e                size,
	output logic                     sign_ext,
	output logic                     is_store,
	output logic [`QUPLS_LANES-1:0] sel,
	output logic                     misalign
);

	// ======================================================================
	// Stage one, address and attributes
	// ======================================================================

	// Raw adder output, only meaningful alongside mem_valid
	value_t agen_res;

	// Request strobe from the decoder
	logic mem_valid;

	qupls_agen i_agen (
		.clk (clk),
		.ir  (ir),
		.a   (a),
		.b   (b),
		.i   (i),
		.res (agen_res)
	);

	qupls_mem_decode i_decode (
		.clk       (clk),
		.rst       (rst),
		.issue     (issue),
		.ir        (ir),
		.mem_valid (mem_valid),
		.size      (size),
		.sign_ext  (sign_ext),
		.is_store  (is_store)
	);

	// The adder has no reset and runs every cycle, so its output is
	// masked to zero whenever no request is present
	assign addr      = mem_valid ? agen_res : '0;
	assign req_valid = mem_valid;

	// ======================================================================
	// Byte lanes
	// ======================================================================

	// Works on the registered address so the mask lines up with addr
	qupls_mem_align i_align (
		.mem_valid (mem_valid),
		.addr      (agen_res),
		.size      (size),
		.sel       (sel),
		.misalign  (misalign)
	);

endmodule

// ==== rtl/qupls_mem_align.sv ====
`timescale 1ns/1ps
`include "qupls_config.svh"

module qupls_mem_align
	import qupls_pkg::*;
(
	input  logic                     mem_valid,
	input  value_t                   addr,
	input  acc_size_e                size,
	output logic [`QUPLS_LANES-1:0] sel,
	output logic                     misalign
);

	// Bits needed to name one byte lane
	localparam int LANE_W = $clog2(`QUPLS_LANES);

	// ======================================================================
	// Size to byte count
	// ======================================================================

	// The size encoding is log2 of the byte count, so one shift suffices
	// One extra bit holds the full lane count for an octa access
	logic [LANE_W:0] nbytes;

	// Low address bits that must be clear for the given size
	logic [LANE_W-1:0] low_mask;

	// Starting lane of the access
	logic [LANE_W-1:0] lane;

	always_comb
	begin
		nbytes   = (LANE_W+1)'(1) << size;
		low_mask = LANE_W'(nbytes - 1'b1);
		lane     = addr[LANE_W-1:0];
	end

	// ======================================================================
	// Alignment check and lane mask
	// ======================================================================

	// Unshifted mask with one bit per byte moved
	logic [`QUPLS_LANES-1:0] base_sel;

	// Mask moved to the starting lane
	logic [`QUPLS_LANES-1:0] shift_sel;

	// Any set address bit inside the access width means misaligned
	logic unaligned;

	always_comb
	begin
		for (int j = 0; j < `QUPLS_LANES; j++)
		begin
			base_sel[j] = (j < int'(nbytes));
		end
		// An aligned access never crosses the top lane, so nothing falls off
		shift_sel = base_sel << lane;
		unaligned = |(lane & low_mask);
	end

	// Both outputs are quiet unless a request is present
	// A misaligned request selects no lanes at all
	always_comb
	begin
		if (!mem_valid)
		begin
			sel      = '0;
			misalign = 1'b0;
		end
		else if (unaligned)
		begin
			sel      = '0;
			misalign = 1'b1;
		end
		else
		begin
			sel      = shift_sel;
			misalign = 1'b0;
		end
	end

endmodule

// ==== rtl/qupls_mem_decode.sv ====
`timescale 1ns/1ps

module qupls_mem_decode
	import qupls_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         issue,
	input  instruction_t ir,
	output logic         mem_valid,
	output acc_size_e    size,
	output logic         sign_ext,
	output logic         is_store
);

	// ======================================================================
	// Opcode classification
	// ======================================================================

	logic      dec_load;
	logic      dec_store;
	logic      dec_amo;
	logic      dec_mem;
	logic      dec_sign;
	acc_size_e dec_size;

	always_comb
	begin
		dec_load  = 1'b0;
		dec_store = 1'b0;
		dec_amo   = 1'b0;
		dec_sign  = 1'b0;
		dec_size  = SZ_BYTE;
		case (ir.any.opcode)
			OP_LDB:  begin dec_load = 1'b1; dec_sign = 1'b1; dec_size = SZ_BYTE;  end
			OP_LDBU: begin dec_load = 1'b1; dec_size = SZ_BYTE;  end
			OP_LDW:  begin dec_load = 1'b1; dec_sign = 1'b1; dec_size = SZ_WYDE;  end
			OP_LDWU: begin dec_load = 1'b1; dec_size = SZ_WYDE;  end
			OP_LDT:  begin dec_load = 1'b1; dec_sign = 1'b1; dec_size = SZ_TETRA; end
			OP_LDTU: begin dec_load = 1'b1; dec_size = SZ_TETRA; end
			// A full octa needs no extension but is flagged signed all the same
			OP_LDO:  begin dec_load = 1'b1; dec_sign = 1'b1; dec_size = SZ_OCTA;  end
			OP_STB:  begin dec_store = 1'b1; dec_size = SZ_BYTE;  end
			OP_STW:  begin dec_store = 1'b1; dec_size = SZ_WYDE;  end
			OP_STT:  begin dec_store = 1'b1; dec_size = SZ_TETRA; end
			OP_STO:  begin dec_store = 1'b1; dec_size = SZ_OCTA;  end
			// Indexed forms read their width from the instruction
			OP_LDX:  begin dec_load = 1'b1; dec_sign = 1'b1; dec_size = ir.lsn.sz; end
			OP_STX:  begin dec_store = 1'b1; dec_size = ir.lsn.sz; end
			// The atomic always moves a whole register
			OP_AMO:  begin dec_amo = 1'b1; dec_size = SZ_OCTA; end
			default: begin dec_size = SZ_BYTE; end
		endcase
		dec_mem = dec_load | dec_store | dec_amo;
	end

	// ======================================================================
	// Result register
	// ======================================================================

	// Registered on the same edge as the address adder so that the
	// attributes and the address leave the front end together
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mem_valid <= 1'b0;
			size      <= SZ_BYTE;
			sign_ext  <= 1'b0;
			is_store  <= 1'b0;
		end
		else
		begin
			mem_valid <= issue & dec_mem;
			// Without an issue the attributes drop back to their idle values
			size      <= (issue && dec_mem) ? dec_size : SZ_BYTE;
			sign_ext  <= issue & dec_sign;
			is_store  <= issue & dec_store;
		end
	end

endmodule

// ==== rtl/qupls_agen.sv ====
`timescale 1ns/1ps

module qupls_agen
	import qupls_pkg::*;
(
	input  logic         clk,
	input  instruction_t ir,
	input  value_t       a,
	input  value_t       b,
	input  value_t       i,
	output value_t       res
);

	// ======================================================================
	// Scaled index
	// ======================================================================

	// Index register scaled by 1, 2, 4 or 8
	value_t bs;

	always_comb
	begin
		bs = b << ir.lsn.sc;
	end

	// ======================================================================
	// Address register
	// ======================================================================

	// The sum is chosen by opcode class and registered every cycle
	// No reset here because the result is only looked at while the
	// decoder reports a valid request
	always_ff @(posedge clk)
	begin
		case (ir.any.opcode)
			// Plain forms, base plus displacement
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT, OP_LDTU, OP_LDO,
			OP_STB, OP_STW, OP_STT, OP_STO:
			begin
				res <= a + i;
			end
			// Indexed forms add the scaled index as well
			OP_LDX, OP_STX:
			begin
				res <= a + bs + i;
			end
			// The atomic uses the unscaled index and no displacement
			OP_AMO:
			begin
				res <= a + b;
			end
			// Anything else is not a memory access
			default:
			begin
				res <= '0;
			end
		endcase
	end

endmodule

// ==== rtl/qupls_pkg.sv ====
`include "qupls_config.svh"

package qupls_pkg;

	// ======================================================================
	// Operand and address values
	// ======================================================================

	// Register operands, the immediate and the effective address share one width
	typedef logic [`QUPLS_VALUE_W-1:0] value_t;

	// ======================================================================
	// Opcodes
	// ======================================================================

	// Only the memory group is decoded by the front end
	// OP_ADD stands in for every opcode that does not touch memory
	typedef enum logic [`QUPLS_OPC_W-1:0] {
		OP_ADD  = 7'h04,
		// Loads, the U forms zero-extend
		OP_LDB  = 7'h40,
		OP_LDBU = 7'h41,
		OP_LDW  = 7'h42,
		OP_LDWU = 7'h43,
		OP_LDT  = 7'h44,
		OP_LDTU = 7'h45,
		OP_LDO  = 7'h46,
		// Indexed load, size comes from the instruction
		OP_LDX  = 7'h47,
		// Stores
		OP_STB  = 7'h50,
		OP_STW  = 7'h51,
		OP_STT  = 7'h52,
		OP_STO  = 7'h53,
		// Indexed store, size comes from the instruction
		OP_STX  = 7'h54,
		// Atomic memory operation, always a full octa
		OP_AMO  = 7'h58
	} opcode_e;

	// ======================================================================
	// Access size and instruction formats
	// ======================================================================

	// Encoded as log2 of the number of bytes moved
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} acc_size_e;

	// Generic view, only the opcode is meaningful here
	typedef struct packed {
		logic [31-`QUPLS_OPC_W:0] payload;
		opcode_e                  opcode;
	} any_fmt_t;

	// Load/store view
	// The sc field scales the index register of LDX and STX
	// and sz gives their access size
	typedef struct packed {
		logic [2:0] pad;
		acc_size_e  sz;
		logic [1:0] sc;
		logic [5:0] rb;
		logic [5:0] ra;
		logic [5:0] rt;
		opcode_e    opcode;
	} lsn_fmt_t;

	// Both views overlay the same 32 instruction bits
	typedef union packed {
		any_fmt_t any;
		lsn_fmt_t lsn;
	} instruction_t;

endpackage

// ==== rtl/qupls_config.svh ====
`ifndef QUPLS_CONFIG_SVH
`define QUPLS_CONFIG_SVH

// ======================================================================
// Core widths for the load/store front end
// ======================================================================

// Width of one register value and of an effective address
`define QUPLS_VALUE_W 64

// One byte lane per eight bits of a register value
`define QUPLS_LANES (`QUPLS_VALUE_W / 8)

// The major opcode occupies the low bits of every instruction
`define QUPLS_OPC_W 7

`endif
